/* src/safe_pkg.sv */
// Safety island mode controller definitions

package safe_pkg;

  ////////////////////////////////////////////////////////////
  // Hart count and vectors
  ////////////////////////////////////////////////////////////

  // Fixed at three, the lockstep logic checks all-three conditions
  localparam int unsigned NHARTS = 3;

  // One bit per hart
  typedef logic [NHARTS-1:0] hart_vec_t;

  ////////////////////////////////////////////////////////////
  // Configuration codes
  ////////////////////////////////////////////////////////////

  localparam logic [1:0] CFG_SINGLE = 2'b00;
  localparam logic [1:0] CFG_TMR    = 2'b01;
  localparam logic [1:0] CFG_DMR    = 2'b10;

  ////////////////////////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////////////////////////

  // Top mode select
  typedef enum logic [2:0] {
    RESET,
    IDLE,
    SINGLE,
    TMR,
    DMR
  } safe_mode_e;

  // Single core boot, run and stop
  typedef enum logic [2:0] {
    S_RESET,
    S_IDLE,
    S_START,
    S_RUN,
    S_SYNC_OFF
  } single_state_e;

  // Per-hart lockstep sequence
  typedef enum logic [2:0] {
    T_RESET,
    T_IDLE,
    T_START,
    T_BOOT,
    T_SYNC,
    T_END_SYNC
  } tmr_state_e;

endpackage

/* src/hart_status_if.sv */
// Hart status and run control
`timescale 1ns/1ps

interface hart_status_if;

  // Per-hart status from the cores
  safe_pkg::hart_vec_t halt_ack;
  safe_pkg::hart_vec_t wfi;
  safe_pkg::hart_vec_t intc_ack;
  safe_pkg::hart_vec_t master;

  // Run control levels
  logic start;
  logic safe_mode;
  logic end_sw;

  modport src (
    output halt_ack,
    output wfi,
    output intc_ack,
    output master,
    output start,
    output safe_mode,
    output end_sw
  );

  modport fsm (
    input halt_ack,
    input wfi,
    input intc_ack,
    input master,
    input start,
    input safe_mode,
    input end_sw
  );

endinterface

/* src/mode_sel_fsm.sv */
// Mode select state machine
`timescale 1ns/1ps

module mode_sel_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  hart_status_if.fsm           status_i,
  input  logic [1:0]           safe_cfg_i,
  input  logic                 single_idle_i,
  input  safe_pkg::hart_vec_t  single_halt_i,
  input  safe_pkg::hart_vec_t  tmr_idle_i,
  input  safe_pkg::hart_vec_t  tmr_halt_i,
  input  safe_pkg::hart_vec_t  tmr_boot_i,
  input  safe_pkg::hart_vec_t  tmr_bus_i,
  input  safe_pkg::hart_vec_t  tmr_voter_i,
  output safe_pkg::safe_mode_e mode_o,
  output safe_pkg::hart_vec_t  halt_o,
  output logic                 start_boot_o,
  output logic                 single_bus_o,
  output logic                 tmr_voter_en_o,
  output logic                 ext_debug_en_o
);

  safe_pkg::safe_mode_e state_q;
  safe_pkg::safe_mode_e state_d;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= safe_pkg::RESET;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      safe_pkg::RESET:
      begin
        state_d = safe_pkg::IDLE;
      end
      safe_pkg::IDLE:
      begin
        // Safe mode picks TMR or DMR, otherwise plain single core
        if (status_i.safe_mode && safe_cfg_i == safe_pkg::CFG_TMR && status_i.start)
          state_d = safe_pkg::TMR;
        else if (status_i.safe_mode && safe_cfg_i == safe_pkg::CFG_DMR && status_i.start)
          state_d = safe_pkg::DMR;
        else if (!status_i.safe_mode && safe_cfg_i == safe_pkg::CFG_SINGLE && status_i.start)
          state_d = safe_pkg::SINGLE;
      end
      safe_pkg::SINGLE:
      begin
        if (!status_i.start && single_idle_i)
          state_d = safe_pkg::IDLE;
      end
      safe_pkg::TMR:
      begin
        // Wait until every hart has finished its sequence
        if (!status_i.start && (&tmr_idle_i))
          state_d = safe_pkg::IDLE;
      end
      safe_pkg::DMR:
      begin
        if (!status_i.safe_mode)
          state_d = safe_pkg::IDLE;
      end
      default:
      begin
        state_d = safe_pkg::IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Merged outputs
  ////////////////////////////////////////////////////////////

  assign mode_o         = state_q;
  assign halt_o         = single_halt_i | tmr_halt_i;
  assign start_boot_o   = (state_q == safe_pkg::SINGLE) | (|tmr_boot_i);
  assign single_bus_o   = |tmr_bus_i;
  assign tmr_voter_en_o = |tmr_voter_i;

  // Debug requests only allowed while no mode is active
  assign ext_debug_en_o = (state_q == safe_pkg::IDLE);

endmodule

/* src/single_mode_fsm.sv */
// Single core run controller
`timescale 1ns/1ps

module single_mode_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  hart_status_if.fsm           status_i,
  input  safe_pkg::safe_mode_e mode_i,
  output logic                 idle_o,
  output safe_pkg::hart_vec_t  halt_o
);

  safe_pkg::single_state_e state_q;
  safe_pkg::single_state_e state_d;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= safe_pkg::S_RESET;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      safe_pkg::S_RESET:
      begin
        state_d = safe_pkg::S_IDLE;
      end
      safe_pkg::S_IDLE:
      begin
        if (mode_i == safe_pkg::SINGLE && status_i.start && !status_i.end_sw)
          state_d = safe_pkg::S_START;
      end
      safe_pkg::S_START:
      begin
        // Master has entered debug halt
        if (status_i.halt_ack == status_i.master)
          state_d = safe_pkg::S_RUN;
      end
      safe_pkg::S_RUN:
      begin
        // Software stop first, then external stop
        if (status_i.end_sw && (&status_i.wfi))
          state_d = safe_pkg::S_IDLE;
        else if (!status_i.start && status_i.halt_ack == '0 && !status_i.end_sw)
          state_d = safe_pkg::S_SYNC_OFF;
      end
      safe_pkg::S_SYNC_OFF:
      begin
        if (status_i.wfi == '0)
          state_d = safe_pkg::S_IDLE;
      end
      default:
      begin
        state_d = safe_pkg::S_IDLE;
      end
    endcase
  end

  assign idle_o = (state_q == safe_pkg::S_IDLE);

  // Halt only the master hart while booting
  assign halt_o = (state_q == safe_pkg::S_START) ? status_i.master : '0;

endmodule

/* src/tmr_hart_fsm.sv */
// Lockstep controller for one hart
`timescale 1ns/1ps

module tmr_hart_fsm #(
  parameter int unsigned HART_IDX = 0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  hart_status_if.fsm           status_i,
  input  safe_pkg::safe_mode_e mode_i,
  output logic                 idle_o,
  output logic                 halt_o,
  output logic                 boot_o,
  output logic                 bus_o,
  output logic                 voter_o,
  output logic                 sync_irq_o
);

  safe_pkg::tmr_state_e state_q;
  safe_pkg::tmr_state_e state_d;

  logic all_wfi;
  logic is_master;

  assign all_wfi   = &status_i.wfi;
  assign is_master = status_i.master[HART_IDX];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= safe_pkg::T_RESET;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      safe_pkg::T_RESET:
      begin
        state_d = safe_pkg::T_IDLE;
      end
      safe_pkg::T_IDLE:
      begin
        if (mode_i == safe_pkg::TMR && status_i.start)
          state_d = safe_pkg::T_START;
      end
      safe_pkg::T_START:
      begin
        if (status_i.halt_ack[HART_IDX])
          state_d = safe_pkg::T_BOOT;
      end
      safe_pkg::T_BOOT:
      begin
        // Halt released, hart is running the boot code
        if (!status_i.halt_ack[HART_IDX])
          state_d = safe_pkg::T_SYNC;
      end
      safe_pkg::T_SYNC:
      begin
        if (all_wfi && status_i.end_sw)
          state_d = safe_pkg::T_IDLE;
        else if (all_wfi && !status_i.safe_mode)
          state_d = safe_pkg::T_END_SYNC;
      end
      safe_pkg::T_END_SYNC:
      begin
        // Master waits for its irq ack, the others for their wfi
        if (is_master && status_i.intc_ack[HART_IDX])
          state_d = safe_pkg::T_IDLE;
        else if (!is_master && status_i.wfi[HART_IDX])
          state_d = safe_pkg::T_IDLE;
      end
      default:
      begin
        state_d = safe_pkg::T_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Output decode
  ////////////////////////////////////////////////////////////

  assign idle_o     = (state_q == safe_pkg::T_IDLE);
  assign halt_o     = (state_q == safe_pkg::T_START);
  assign boot_o     = (state_q == safe_pkg::T_START) || (state_q == safe_pkg::T_BOOT);
  assign bus_o      = boot_o || (state_q == safe_pkg::T_SYNC);
  assign voter_o    = bus_o;
  assign sync_irq_o = (state_q == safe_pkg::T_END_SYNC) && is_master;

endmodule

/* src/safe_island_ctrl.sv */
// Safety island mode controller
`timescale 1ns/1ps

module safe_island_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                safe_mode_i,
  input  logic [1:0]          safe_cfg_i,
  input  logic                start_i,
  input  logic                end_sw_i,
  input  safe_pkg::hart_vec_t halt_ack_i,
  input  safe_pkg::hart_vec_t hart_wfi_i,
  input  safe_pkg::hart_vec_t intc_ack_i,
  input  safe_pkg::hart_vec_t master_core_i,
  output safe_pkg::hart_vec_t halt_o,
  output safe_pkg::hart_vec_t sync_irq_o,
  output logic                start_boot_o,
  output logic                single_bus_o,
  output logic                tmr_voter_en_o,
  output logic                ext_debug_en_o
);

  safe_pkg::safe_mode_e mode;
  logic                 single_idle;
  safe_pkg::hart_vec_t  single_halt;
  safe_pkg::hart_vec_t  tmr_idle;
  safe_pkg::hart_vec_t  tmr_halt;
  safe_pkg::hart_vec_t  tmr_boot;
  safe_pkg::hart_vec_t  tmr_bus;
  safe_pkg::hart_vec_t  tmr_voter;

  hart_status_if u_status ();

  // Core status into the shared bundle
  assign u_status.halt_ack  = halt_ack_i;
  assign u_status.wfi       = hart_wfi_i;
  assign u_status.intc_ack  = intc_ack_i;
  assign u_status.master    = master_core_i;
  assign u_status.start     = start_i;
  assign u_status.safe_mode = safe_mode_i;
  assign u_status.end_sw    = end_sw_i;

  mode_sel_fsm u_mode_sel_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .status_i       (u_status.fsm),
    .safe_cfg_i     (safe_cfg_i),
    .single_idle_i  (single_idle),
    .single_halt_i  (single_halt),
    .tmr_idle_i     (tmr_idle),
    .tmr_halt_i     (tmr_halt),
    .tmr_boot_i     (tmr_boot),
    .tmr_bus_i      (tmr_bus),
    .tmr_voter_i    (tmr_voter),
    .mode_o         (mode),
    .halt_o         (halt_o),
    .start_boot_o   (start_boot_o),
    .single_bus_o   (single_bus_o),
    .tmr_voter_en_o (tmr_voter_en_o),
    .ext_debug_en_o (ext_debug_en_o)
  );

  single_mode_fsm u_single_mode_fsm (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .status_i (u_status.fsm),
    .mode_i   (mode),
    .idle_o   (single_idle),
    .halt_o   (single_halt)
  );

  // One lockstep machine per hart
  for (genvar i = 0; i < safe_pkg::NHARTS; i++)
  begin : g_tmr_hart
    tmr_hart_fsm #(
      .HART_IDX (i)
    ) u_tmr_hart_fsm (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .status_i   (u_status.fsm),
      .mode_i     (mode),
      .idle_o     (tmr_idle[i]),
      .halt_o     (tmr_halt[i]),
      .boot_o     (tmr_boot[i]),
      .bus_o      (tmr_bus[i]),
      .voter_o    (tmr_voter[i]),
      .sync_irq_o (sync_irq_o[i])
    );
  end

endmodule

/* bench/tb_clk_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 8 ns period
  localparam int unsigned HALF_PERIOD_NS = 4;
  localparam int unsigned RESET_CYCLES   = 10;

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial
  begin
    rst_no <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* bench/safe_island_ctrl_sva.sv */
// Mode controller assertions
`timescale 1ns/1ps

module safe_island_ctrl_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input safe_pkg::hart_vec_t halt_i,
  input safe_pkg::hart_vec_t sync_irq_i,
  input logic                start_boot_i,
  input logic                ext_debug_en_i
);

  // No hart is halted while the controller sits in reset
  halt_in_reset: assert property (@(posedge clk_i) !rst_ni |-> halt_i == '0)
    else $error("halt_o is active during reset");

  // Only the master hart ever gets the sync interrupt
  sync_irq_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(sync_irq_i)
  )
    else $error("sync_irq_o is high on more than one hart");

  // Debug stays closed while any hart boots
  boot_blocks_debug: assert property (
    @(posedge clk_i) disable iff (!rst_ni) start_boot_i |-> !ext_debug_en_i
  )
    else $error("ext_debug_en_o is high while start_boot_o is high");

endmodule

/* bench/safe_island_ctrl_tb.sv */
// Mode controller testbench
`timescale 1ns/1ps

module safe_island_ctrl_tb;

  ////////////////////////////////////////////////////////////
  // Run length
  ////////////////////////////////////////////////////////////

  localparam int unsigned CLK_PERIOD_NS     = 8;
  localparam int unsigned RESET_CYCLES      = 14;
  localparam int unsigned SINGLE_SW_CYCLES  = 16;
  localparam int unsigned SINGLE_EXT_CYCLES = 18;
  localparam int unsigned TMR_BOOT_CYCLES   = 18;
  localparam int unsigned TMR_END_CYCLES    = 20;
  localparam int unsigned DMR_CYCLES        = 14;
  localparam int unsigned WATCHDOG_NS = 2 * CLK_PERIOD_NS * (RESET_CYCLES + SINGLE_SW_CYCLES
    + SINGLE_EXT_CYCLES + TMR_BOOT_CYCLES + TMR_END_CYCLES + DMR_CYCLES);

  logic                clk;
  logic                rst_n;
  logic                safe_mode;
  logic [1:0]          safe_cfg;
  logic                start;
  logic                end_sw;
  safe_pkg::hart_vec_t halt_ack;
  safe_pkg::hart_vec_t wfi;
  safe_pkg::hart_vec_t intc_ack;
  safe_pkg::hart_vec_t master;
  safe_pkg::hart_vec_t halt;
  safe_pkg::hart_vec_t sync_irq;
  logic                start_boot;
  logic                single_bus;
  logic                tmr_voter_en;
  logic                ext_debug_en;

  logic [31:0] lcg_state;

  tb_clk_gen u_tb_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  safe_island_ctrl u_safe_island_ctrl (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .safe_mode_i    (safe_mode),
    .safe_cfg_i     (safe_cfg),
    .start_i        (start),
    .end_sw_i       (end_sw),
    .halt_ack_i     (halt_ack),
    .hart_wfi_i     (wfi),
    .intc_ack_i     (intc_ack),
    .master_core_i  (master),
    .halt_o         (halt),
    .sync_irq_o     (sync_irq),
    .start_boot_o   (start_boot),
    .single_bus_o   (single_bus),
    .tmr_voter_en_o (tmr_voter_en),
    .ext_debug_en_o (ext_debug_en)
  );

  bind safe_island_ctrl safe_island_ctrl_sva u_safe_island_ctrl_sva (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .halt_i         (halt_o),
    .sync_irq_i     (sync_irq_o),
    .start_boot_i   (start_boot_o),
    .ext_debug_en_i (ext_debug_en_o)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // One-hot master from the upper LCG bits
  task automatic pick_master(output safe_pkg::hart_vec_t m);
    lcg_state = lcg_next(lcg_state);
    m = '0;
    m[(lcg_state >> 16) % safe_pkg::NHARTS] = 1'b1;
  endtask

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  // n rising edges, then sample at the falling edge
  task automatic settle(input int unsigned n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic wait_debug_en(input int unsigned max_cycles);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (ext_debug_en !== 1'b1)
    begin
      if (waited == max_cycles)
      begin
        $display("Timeout at %0t ns: controller did not return to idle within %0d cycles",
                 $time, max_cycles);
        $display("Simulation FAILED");
        $fatal(1, "no return to idle");
      end
      else
      begin
        waited++;
        @(negedge clk);
      end
    end
  endtask

  // Mode request with all hart status cleared
  task automatic apply_request(input logic [1:0] cfg, input logic safe,
                               input safe_pkg::hart_vec_t m);
    @(posedge clk);
    safe_cfg  <= cfg;
    safe_mode <= safe;
    start     <= 1'b1;
    master    <= m;
    end_sw    <= 1'b0;
    halt_ack  <= '0;
    wfi       <= '0;
    intc_ack  <= '0;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_outputs();
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_eq("halt_o", halt, 0);
    check_eq("sync_irq_o", sync_irq, 0);
    check_eq("start_boot_o", start_boot, 0);
    check_eq("single_bus_o", single_bus, 0);
    check_eq("tmr_voter_en_o", tmr_voter_en, 0);
    check_eq("ext_debug_en_o", ext_debug_en, 0);
    settle(1);
    check_eq("ext_debug_en_o", ext_debug_en, 1);
  endtask

  task automatic single_sw_stop();
    safe_pkg::hart_vec_t m;
    pick_master(m);
    apply_request(safe_pkg::CFG_SINGLE, 1'b0, m);
    settle(2);
    check_eq("halt_o", halt, m);
    check_eq("start_boot_o", start_boot, 1);
    check_eq("ext_debug_en_o", ext_debug_en, 0);
    @(posedge clk);
    halt_ack <= m;
    settle(1);
    check_eq("halt_o", halt, 0);
    // Software finished with every hart asleep
    @(posedge clk);
    halt_ack <= '0;
    end_sw   <= 1'b1;
    wfi      <= '1;
    settle(1);
    check_eq("start_boot_o", start_boot, 1);
    check_eq("ext_debug_en_o", ext_debug_en, 0);
    // Single machine already idle, so the mode follows start at once
    @(posedge clk);
    start  <= 1'b0;
    end_sw <= 1'b0;
    wfi    <= '0;
    settle(1);
    check_eq("ext_debug_en_o", ext_debug_en, 1);
    check_eq("start_boot_o", start_boot, 0);
  endtask

  task automatic single_ext_stop();
    safe_pkg::hart_vec_t m;
    pick_master(m);
    apply_request(safe_pkg::CFG_SINGLE, 1'b0, m);
    settle(2);
    check_eq("halt_o", halt, m);
    @(posedge clk);
    halt_ack <= m;
    settle(1);
    check_eq("halt_o", halt, 0);
    @(posedge clk);
    start    <= 1'b0;
    halt_ack <= '0;
    wfi      <= '1;
    // Held in sync-off while wfi stays up
    settle(3);
    check_eq("ext_debug_en_o", ext_debug_en, 0);
    check_eq("start_boot_o", start_boot, 1);
    @(posedge clk);
    wfi <= '0;
    wait_debug_en(4);
    check_eq("start_boot_o", start_boot, 0);
    check_eq("halt_o", halt, 0);
  endtask

  // Lockstep entry up to the sync state
  task automatic tmr_boot_to_sync(input safe_pkg::hart_vec_t m);
    safe_pkg::hart_vec_t all_harts;
    all_harts = '1;
    apply_request(safe_pkg::CFG_TMR, 1'b1, m);
    settle(2);
    check_eq("halt_o", halt, all_harts);
    check_eq("start_boot_o", start_boot, 1);
    check_eq("single_bus_o", single_bus, 1);
    check_eq("tmr_voter_en_o", tmr_voter_en, 1);
    @(posedge clk);
    halt_ack <= '1;
    settle(1);
    check_eq("halt_o", halt, 0);
    check_eq("start_boot_o", start_boot, 1);
    @(posedge clk);
    halt_ack <= '0;
    settle(1);
    check_eq("start_boot_o", start_boot, 0);
    check_eq("single_bus_o", single_bus, 1);
    check_eq("tmr_voter_en_o", tmr_voter_en, 1);
  endtask

  task automatic tmr_boot();
    safe_pkg::hart_vec_t m;
    pick_master(m);
    tmr_boot_to_sync(m);
    @(posedge clk);
    wfi    <= '1;
    end_sw <= 1'b1;
    start  <= 1'b0;
    settle(1);
    check_eq("single_bus_o", single_bus, 0);
    check_eq("tmr_voter_en_o", tmr_voter_en, 0);
    check_eq("start_boot_o", start_boot, 0);
    wait_debug_en(4);
    @(posedge clk);
    wfi    <= '0;
    end_sw <= 1'b0;
  endtask

  task automatic tmr_end_sync();
    safe_pkg::hart_vec_t m;
    pick_master(m);
    tmr_boot_to_sync(m);
    @(posedge clk);
    wfi       <= '1;
    safe_mode <= 1'b0;
    start     <= 1'b0;
    settle(1);
    check_eq("sync_irq_o", sync_irq, m);
    check_eq("single_bus_o", single_bus, 0);
    check_eq("tmr_voter_en_o", tmr_voter_en, 0);
    // Master keeps waiting for its interrupt ack
    settle(1);
    check_eq("sync_irq_o", sync_irq, m);
    check_eq("ext_debug_en_o", ext_debug_en, 0);
    @(posedge clk);
    intc_ack <= m;
    wait_debug_en(4);
    check_eq("sync_irq_o", sync_irq, 0);
    @(posedge clk);
    intc_ack <= '0;
    wfi      <= '0;
  endtask

  task automatic dmr_entry();
    safe_pkg::hart_vec_t m;
    pick_master(m);
    apply_request(safe_pkg::CFG_DMR, 1'b1, m);
    settle(1);
    check_eq("ext_debug_en_o", ext_debug_en, 0);
    check_eq("start_boot_o", start_boot, 0);
    settle(2);
    check_eq("start_boot_o", start_boot, 0);
    check_eq("halt_o", halt, 0);
    @(posedge clk);
    safe_mode <= 1'b0;
    wait_debug_en(4);
    @(posedge clk);
    start <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    lcg_state   = 32'd25172;
    safe_mode  <= 1'b0;
    safe_cfg   <= safe_pkg::CFG_SINGLE;
    start      <= 1'b0;
    end_sw     <= 1'b0;
    halt_ack   <= '0;
    wfi        <= '0;
    intc_ack   <= '0;
    master     <= 3'b001;
    reset_outputs();
    single_sw_stop();
    single_ext_stop();
    tmr_boot();
    tmr_end_sync();
    dmr_entry();
    $display("Simulation PASSED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* verilog.f */
src/safe_pkg.sv
src/hart_status_if.sv
src/mode_sel_fsm.sv
src/single_mode_fsm.sv
src/tmr_hart_fsm.sv
src/safe_island_ctrl.sv
bench/tb_clk_gen.sv
bench/safe_island_ctrl_sva.sv
bench/safe_island_ctrl_tb.sv

/* Bender.yml */
package:
  name: safe_island_ctrl

sources:
  # RTL in compile order
  - files:
      - src/safe_pkg.sv
      - src/hart_status_if.sv
      - src/mode_sel_fsm.sv
      - src/single_mode_fsm.sv
      - src/tmr_hart_fsm.sv
      - src/safe_island_ctrl.sv
  # Testbench, top module safe_island_ctrl_tb
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/safe_island_ctrl_sva.sv
      - bench/safe_island_ctrl_tb.sv
